//--- Makefile
VERILATOR ?= verilator
TOP       ?= uart_tx_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG) || { echo "Simulation failed"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/uart_tx_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_asserts (
    input wire                       clk,
    input wire                       reset_n,
    input wire                       wr_valid_i,
    input wire                       credit_i,
    input wire                       pop_i,
    input wire                       avail_i,
    input wire                       tx_i,
    input wire uart_pkg::tx_state_t  state_i,
    input wire uart_pkg::fifo_ptr_t  wr_ptr_i,
    input wire uart_pkg::fifo_ptr_t  rd_ptr_i
);

    import uart_pkg::*;

    int        credits;   // Host-side credit count
    fifo_ptr_t occupancy;

    assign occupancy = wr_ptr_i - rd_ptr_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            credits <= TX_FIFO_DEPTH;
        end else begin
            credits <= credits + int'(credit_i) - int'(wr_valid_i);
        end
    end

    a_write_has_credit: assert property (@(posedge clk) disable iff (!reset_n)
        wr_valid_i |-> (credits > 0)) else $error("write without credit");

    a_fifo_bound: assert property (@(posedge clk) disable iff (!reset_n)
        int'(occupancy) <= TX_FIFO_DEPTH) else $error("FIFO occupancy above depth");

    // No pop while a start or data bit is on the line
    a_pop_needs_avail: assert property (@(posedge clk) disable iff (!reset_n)
        pop_i |-> (avail_i && tx_i)) else $error("pop while FIFO empty or mid-frame");

    a_idle_line_high: assert property (@(posedge clk) disable iff (!reset_n)
        (state_i == TX_IDLE) |-> tx_i) else $error("line low while idle");

endmodule

bind uart_tx_top uart_tx_asserts u_asserts (
    .clk        (clk),
    .reset_n    (reset_n),
    .wr_valid_i (wr_valid_i),
    .credit_i   (credit_o),
    .pop_i      (fifo_pop),
    .avail_i    (fifo_avail),
    .tx_i       (tx_o),
    .state_i    (u_transmitter.state),
    .wr_ptr_i   (u_tx_fifo.wr_ptr),
    .rd_ptr_i   (u_tx_fifo.rd_ptr)
);

`default_nettype wire

//--- dv/uart_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_tb;

    import uart_pkg::*;

    localparam int N_ENTRIES = 8;
    localparam int BURST_CFG = 1;
    localparam int BURST_LEN = 6;   // More than the depth, so the host stalls
    localparam int BP_CFG    = 0;

    logic       clk;
    logic       reset_n;
    logic       wr_valid;
    uart_byte_t wr_data;
    logic       credit;
    baud_div_t  baud_div;
    data_bits_t data_bits;
    stop_bits_t stop_bits;
    logic       parity_en;
    logic       parity_odd;
    logic       tx_en;
    logic       tx;
    logic       tx_busy;

    // Stimulus table
    uart_byte_t tab_data [N_ENTRIES];
    data_bits_t tab_db   [N_ENTRIES];
    stop_bits_t tab_sb   [N_ENTRIES];
    logic       tab_pen  [N_ENTRIES];
    logic       tab_podd [N_ENTRIES];
    int         tab_div  [N_ENTRIES];

    uart_byte_t exp_q [$];
    int writes;
    int returned;
    int min_credits;
    int frames_done;
    int falls;
    int errors;
    int checks;
    int cycles;
    int limit;

    uart_tx_top u_uart_tx_top (
        .clk          (clk),
        .reset_n      (reset_n),
        .wr_valid_i   (wr_valid),
        .wr_data_i    (wr_data),
        .credit_o     (credit),
        .baud_div_i   (baud_div),
        .data_bits_i  (data_bits),
        .stop_bits_i  (stop_bits),
        .parity_en_i  (parity_en),
        .parity_odd_i (parity_odd),
        .tx_en_i      (tx_en),
        .tx_o         (tx),
        .tx_busy_o    (tx_busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (credit) returned <= returned + 1;
    end

    always @(negedge tx) begin
        if (reset_n) falls = falls + 1;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: run went past %0d cycles without finishing", limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic set_entry(input int i, input uart_byte_t d, input data_bits_t db,
                             input stop_bits_t sb, input logic pen, input logic podd,
                             input int div);
        tab_data[i] = d;
        tab_db[i]   = db;
        tab_sb[i]   = sb;
        tab_pen[i]  = pen;
        tab_podd[i] = podd;
        tab_div[i]  = div;
    endtask

    function automatic int stop_count(input stop_bits_t sb);
        if (sb == 2'b00) return 1;
        if (sb == 2'b11) return 3;
        return 2;
    endfunction

    // Start bit plus one spare bit slot for tick phase
    function automatic int frame_cycles(input int c);
        return (2 + int'(tab_db[c]) + 5 + int'(tab_pen[c]) + stop_count(tab_sb[c]))
               * tab_div[c];
    endfunction

    task automatic check_value(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("** Error at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic apply_cfg(input int c);
        @(posedge clk);
        #1;
        baud_div   = baud_div_t'(tab_div[c]);
        data_bits  = tab_db[c];
        stop_bits  = tab_sb[c];
        parity_en  = tab_pen[c];
        parity_odd = tab_podd[c];
    endtask

    task automatic write_byte(input uart_byte_t b);
        @(posedge clk);
        #1;
        while (TX_FIFO_DEPTH - writes + returned == 0) begin
            @(posedge clk);
            #1;
        end
        wr_valid = 1'b1;
        wr_data  = b;
        exp_q.push_back(b);
        writes++;
        if (TX_FIFO_DEPTH - writes + returned < min_credits) begin
            min_credits = TX_FIFO_DEPTH - writes + returned;
        end
        @(posedge clk);
        #1;
        wr_valid = 1'b0;
    endtask

    // Samples at falling clock edges, mid-bit
    task automatic decode_frame(input int c, input bit at_mid);
        uart_byte_t exp_b;
        uart_byte_t mask;
        uart_byte_t got;
        int         nb;
        int         div;
        nb   = int'(tab_db[c]) + 5;
        div  = tab_div[c];
        mask = 8'hff >> (8 - nb);
        got  = '0;
        if (at_mid) begin
            repeat (div) @(negedge clk);   // Slot right after the last stop bit
        end else begin
            @(negedge tx);
            repeat (div / 2) @(negedge clk);
        end
        if (exp_q.size() == 0) begin
            errors++;
            $display("Frame started with no byte left to expect at %0t", $time);
            exp_b = '0;
        end else begin
            exp_b = exp_q.pop_front();
        end
        check_value(tx, 0, "start bit");
        check_value(tx_busy, 1, "busy during frame");
        for (int i = 0; i < nb; i++) begin
            repeat (div) @(negedge clk);
            got[i] = tx;
        end
        check_value(got, exp_b & mask, "data bits");
        if (tab_pen[c]) begin
            repeat (div) @(negedge clk);
            // Ones in data plus parity, odd only in odd mode
            check_value(($countones(exp_b & mask) + int'(tx)) % 2, int'(tab_podd[c]),
                        "parity bit");
        end
        for (int s = 0; s < stop_count(tab_sb[c]); s++) begin
            repeat (div) @(negedge clk);
            check_value(tx, 1, "stop bit");
        end
        frames_done++;
        check_value(returned, frames_done, "credits returned");
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (tx_busy) @(negedge clk);
    endtask

    initial begin
        void'($urandom(32'h9153));
        reset_n    = 1'b0;
        wr_valid   = 1'b0;
        wr_data    = '0;
        baud_div   = baud_div_t'(4);
        data_bits  = 2'b11;
        stop_bits  = 2'b00;
        parity_en  = 1'b0;
        parity_odd = 1'b0;
        tx_en      = 1'b1;
        writes = 0;
        returned = 0;
        min_credits = TX_FIFO_DEPTH;
        frames_done = 0;
        falls = 0;
        errors = 0;
        checks = 0;
        cycles = 0;

        set_entry(0, 8'hA5, 2'b11, 2'b00, 1'b0, 1'b0, 4);
        set_entry(1, 8'h3C, 2'b00, 2'b01, 1'b1, 1'b0, 6);
        set_entry(2, 8'h5A, 2'b01, 2'b10, 1'b1, 1'b1, 5);
        set_entry(3, 8'hF0, 2'b10, 2'b11, 1'b0, 1'b0, 2);
        set_entry(4, 8'h96, 2'b11, 2'b01, 1'b1, 1'b1, 8);
        set_entry(5, 8'h1F, 2'b00, 2'b00, 1'b1, 1'b1, 3);
        set_entry(6, 8'h7E, 2'b10, 2'b00, 1'b1, 1'b0, 4);
        set_entry(7, 8'h01, 2'b11, 2'b11, 1'b1, 1'b0, 2);

        limit = 2000;
        for (int i = 0; i < N_ENTRIES; i++) limit += frame_cycles(i) + 20;
        limit += BURST_LEN * (frame_cycles(BURST_CFG) + 4);
        limit += 2 * frame_cycles(BP_CFG);

        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // Quiet line after reset
        repeat (20) @(negedge clk) check_value(tx, 1, "idle line after reset");
        check_value(returned, 0, "credits before any write");
        check_value(tx_busy, 0, "busy after reset");

        // One frame per table entry
        for (int i = 0; i < N_ENTRIES; i++) begin
            apply_cfg(i);
            repeat ($urandom_range(0, 7)) @(posedge clk);
            write_byte(tab_data[i]);
            decode_frame(i, 1'b0);
            wait_idle();
        end

        // Back-to-back burst beyond the credit limit
        apply_cfg(BURST_CFG);
        fork
            begin
                for (int k = 0; k < BURST_LEN; k++) write_byte(uart_byte_t'(8'h41 + 8'(k * 7)));
            end
            begin
                for (int k = 0; k < BURST_LEN; k++) decode_frame(BURST_CFG, k != 0);
            end
        join
        wait_idle();
        check_value(min_credits, 0, "credits used up in burst");

        // Transmit disabled holds bytes in the FIFO
        apply_cfg(BP_CFG);
        @(posedge clk);
        #1;
        tx_en = 1'b0;
        begin
            int falls_before;
            int returned_before;
            falls_before    = falls;
            returned_before = returned;
            write_byte(8'hC3);
            write_byte(8'h2D);
            repeat (100) @(posedge clk);
            check_value(falls, falls_before, "frames while disabled");
            check_value(returned, returned_before, "credits while disabled");
        end
        #1;
        tx_en = 1'b1;
        decode_frame(BP_CFG, 1'b0);
        decode_frame(BP_CFG, 1'b1);
        wait_idle();
        check_value(returned, writes, "credits after drain");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
source/uart_pkg.sv
source/uart_baud_gen.sv
source/uart_tx_fifo.sv
source/uart_transmitter.sv
source/uart_tx_top.sv
dv/uart_tx_asserts.sv
dv/uart_tx_tb.sv

//--- source/uart_baud_gen.sv
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire uart_pkg::baud_div_t baud_div_i,
    output logic                     tick_o
);

    import uart_pkg::*;

    baud_div_t cnt;

    assign tick_o = (cnt == baud_div_t'(1));

    // Free-running down-counter, divisor sampled only at reload
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt <= '0;
        end else if (tick_o || (cnt == '0)) begin
            cnt <= baud_div_i;
        end else begin
            cnt <= cnt - baud_div_t'(1);
        end
    end

endmodule

`default_nettype wire

//--- source/uart_pkg.sv
`default_nettype none

package uart_pkg;

    localparam int UART_BYTE_W = 8;
    localparam int BAUD_DIV_W  = 16;

    typedef logic [UART_BYTE_W-1:0] uart_byte_t;
    typedef logic [BAUD_DIV_W-1:0]  baud_div_t;   // Clock cycles per bit
    typedef logic [1:0]             data_bits_t;
    typedef logic [1:0]             stop_bits_t;

    // Depth is also the host's credit count after reset
    localparam int TX_FIFO_DEPTH = 4;
    localparam int TX_FIFO_AW    = $clog2(TX_FIFO_DEPTH);

    typedef logic [TX_FIFO_AW:0] fifo_ptr_t;      // Extra wrap bit

    // Data bit codes
    localparam data_bits_t DATA_BITS_5 = 2'b00;
    localparam data_bits_t DATA_BITS_6 = 2'b01;
    localparam data_bits_t DATA_BITS_7 = 2'b10;
    localparam data_bits_t DATA_BITS_8 = 2'b11;

    // Stop bit codes
    localparam stop_bits_t STOP_BITS_1  = 2'b00;
    localparam stop_bits_t STOP_BITS_2  = 2'b01;
    localparam stop_bits_t STOP_BITS_2B = 2'b10;  // Spare code, two stop bits as well
    localparam stop_bits_t STOP_BITS_3  = 2'b11;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_t;

endpackage

`default_nettype wire

//--- source/uart_transmitter.sv
`timescale 1ns/1ps
`default_nettype none

module uart_transmitter (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire                       tick_i,
    input  wire                       tx_en_i,
    input  wire uart_pkg::data_bits_t data_bits_i,
    input  wire uart_pkg::stop_bits_t stop_bits_i,
    input  wire                       parity_en_i,
    input  wire                       parity_odd_i,
    input  wire uart_pkg::uart_byte_t byte_i,
    input  wire                       avail_i,
    output logic                      pop_o,
    output logic                      tx_o,
    output logic                      tx_busy_o
);

    import uart_pkg::*;

    tx_state_t  state;
    uart_byte_t shift_reg;
    logic [2:0] bit_cnt;
    logic [2:0] last_bit;
    logic [1:0] stop_cnt;
    logic [1:0] stop_num;
    logic       parity_acc;
    logic       frame_done;

    // Index of the last data bit
    always_comb begin
        last_bit = 3'd7;
        case (data_bits_i)
            DATA_BITS_5: last_bit = 3'd4;
            DATA_BITS_6: last_bit = 3'd5;
            DATA_BITS_7: last_bit = 3'd6;
            DATA_BITS_8: last_bit = 3'd7;
        endcase
    end

    always_comb begin
        stop_num = 2'd1;
        case (stop_bits_i)
            STOP_BITS_1:  stop_num = 2'd1;
            STOP_BITS_2:  stop_num = 2'd2;
            STOP_BITS_2B: stop_num = 2'd2;
            STOP_BITS_3:  stop_num = 2'd3;
        endcase
    end

    // Tick that closes the last stop bit
    assign frame_done = (state == TX_STOP) && tick_i && (stop_cnt == stop_num);

    // Pop from idle, or chain the next frame with no gap
    assign pop_o = tx_en_i && avail_i && ((state == TX_IDLE) || frame_done);

    assign tx_busy_o = (state != TX_IDLE);

    always_ff @(posedge clk) begin
        if (pop_o) begin
            shift_reg <= byte_i;
        end else if ((state == TX_DATA) && tick_i) begin
            shift_reg <= shift_reg >> 1;   // LSB first
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= TX_IDLE;
            tx_o       <= 1'b1;
            bit_cnt    <= '0;
            stop_cnt   <= '0;
            parity_acc <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (pop_o) begin
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (tick_i) begin
                        tx_o  <= 1'b0;     // Start bit
                        state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (tick_i) begin
                        tx_o       <= shift_reg[0];
                        parity_acc <= parity_acc ^ shift_reg[0];
                        bit_cnt    <= bit_cnt + 3'd1;
                        if (bit_cnt == last_bit) begin
                            state <= parity_en_i ? TX_PARITY : TX_STOP;
                        end
                    end
                end
                TX_PARITY: begin
                    if (tick_i) begin
                        tx_o  <= parity_acc ^ parity_odd_i;
                        state <= TX_STOP;
                    end
                end
                TX_STOP: begin
                    if (tick_i) begin
                        if (stop_cnt != stop_num) begin
                            tx_o     <= 1'b1;
                            stop_cnt <= stop_cnt + 2'd1;
                        end else if (pop_o) begin
                            // Next byte waiting, its start bit begins now
                            tx_o  <= 1'b0;
                            state <= TX_DATA;
                        end else begin
                            state <= TX_IDLE;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase

            if (pop_o) begin
                bit_cnt    <= '0;
                stop_cnt   <= '0;
                parity_acc <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/uart_tx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_fifo (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire                       wr_valid_i,
    input  wire uart_pkg::uart_byte_t wr_data_i,
    input  wire                       pop_i,
    output uart_pkg::uart_byte_t      byte_o,
    output logic                      avail_o,
    output logic                      credit_o
);

    import uart_pkg::*;

    uart_byte_t mem [TX_FIFO_DEPTH];
    fifo_ptr_t  wr_ptr;
    fifo_ptr_t  rd_ptr;

    assign avail_o = (wr_ptr != rd_ptr);
    assign byte_o  = mem[rd_ptr[TX_FIFO_AW-1:0]];   // Head entry

    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            mem[wr_ptr[TX_FIFO_AW-1:0]] <= wr_data_i;
        end
    end

    // Host only writes with credit in hand, so no full check
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
        end else if (wr_valid_i) begin
            wr_ptr <= wr_ptr + fifo_ptr_t'(1);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
        end else if (pop_i) begin
            rd_ptr <= rd_ptr + fifo_ptr_t'(1);
        end
    end

    // One credit back per popped byte
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            credit_o <= 1'b0;
        end else begin
            credit_o <= pop_i;
        end
    end

endmodule

`default_nettype wire

//--- source/uart_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_top (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire                       wr_valid_i,
    input  wire uart_pkg::uart_byte_t wr_data_i,
    output wire                       credit_o,
    input  wire uart_pkg::baud_div_t  baud_div_i,
    input  wire uart_pkg::data_bits_t data_bits_i,
    input  wire uart_pkg::stop_bits_t stop_bits_i,
    input  wire                       parity_en_i,
    input  wire                       parity_odd_i,
    input  wire                       tx_en_i,
    output wire                       tx_o,
    output wire                       tx_busy_o
);

    import uart_pkg::*;

    logic       tick;
    uart_byte_t fifo_byte;
    logic       fifo_avail;
    logic       fifo_pop;

    uart_baud_gen u_baud_gen (
        .clk        (clk),
        .reset_n    (reset_n),
        .baud_div_i (baud_div_i),
        .tick_o     (tick)
    );

    uart_tx_fifo u_tx_fifo (
        .clk        (clk),
        .reset_n    (reset_n),
        .wr_valid_i (wr_valid_i),
        .wr_data_i  (wr_data_i),
        .pop_i      (fifo_pop),
        .byte_o     (fifo_byte),
        .avail_o    (fifo_avail),
        .credit_o   (credit_o)
    );

    uart_transmitter u_transmitter (
        .clk          (clk),
        .reset_n      (reset_n),
        .tick_i       (tick),
        .tx_en_i      (tx_en_i),
        .data_bits_i  (data_bits_i),
        .stop_bits_i  (stop_bits_i),
        .parity_en_i  (parity_en_i),
        .parity_odd_i (parity_odd_i),
        .byte_i       (fifo_byte),
        .avail_i      (fifo_avail),
        .pop_o        (fifo_pop),
        .tx_o         (tx_o),
        .tx_busy_o    (tx_busy_o)
    );

endmodule

`default_nettype wire
